// ==== logic/cache_dir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_dir_top #(
   parameter int rep_policy = cache_pkg::rep_plru_tree
) (
   input  logic                          clk,
   input  logic                          rst_n,
   // request
   input  logic                          req_valid,
   output logic                          req_ready,
   input  logic [cache_pkg::addr_w-1:0]  req_addr,
   // response
   output logic                          resp_valid,
   input  logic                          resp_ready,
   output logic                          resp_hit,
   output logic [cache_pkg::nways_w-1:0] resp_way,
   output logic                          resp_evicted,
   output logic [cache_pkg::tag_w-1:0]   resp_tag
);

   import cache_pkg::*;

   logic       q_valid;
   logic       q_ready;
   req_word_t  q_data;
   logic       r_valid;
   logic       r_ready;
   resp_word_t r_data;
   resp_word_t resp_data;   // head of the response fifo

   cache_fifo #(
      .payload_t (req_word_t)
   ) req_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (req_valid),
      .in_ready  (req_ready),
      .in_data   (req_addr),
      .out_valid (q_valid),
      .out_ready (q_ready),
      .out_data  (q_data)
   );

   cache_tag_lookup #(
      .rep_policy (rep_policy)
   ) lookup (
      .clk     (clk),
      .rst_n   (rst_n),
      .q_valid (q_valid),
      .q_ready (q_ready),
      .q_data  (q_data),
      .r_valid (r_valid),
      .r_ready (r_ready),
      .r_data  (r_data)
   );

   cache_fifo #(
      .payload_t (resp_word_t)
   ) resp_fifo (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (r_valid),
      .in_ready  (r_ready),
      .in_data   (r_data),
      .out_valid (resp_valid),
      .out_ready (resp_ready),
      .out_data  (resp_data)
   );

   // split the payload onto loose ports
   assign resp_hit     = resp_data.hit;
   assign resp_way     = resp_data.way;
   assign resp_evicted = resp_data.evicted;
   assign resp_tag     = resp_data.tag_echo;

endmodule

`default_nettype wire

// ==== logic/cache_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_fifo #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   // write side
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   // read side
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   import cache_pkg::*;

   payload_t              mem [fifo_depth];   // storage, no reset needed
   logic [fifo_ptr_w-1:0] wr_ptr;
   logic [fifo_ptr_w-1:0] rd_ptr;
   logic [fifo_ptr_w:0]   count;              // one extra bit so full fits
   logic                  push;
   logic                  pop;

   assign in_ready  = (count != fifo_depth[fifo_ptr_w:0]);   // only full blocks the writer
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];                           // head of queue, straight out

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   // payload write, pointers wrap on their own since depth is a power of 2
   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         // occupancy only moves when exactly one side transfers
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/cache_line_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_line_regfile #(
   parameter int data_w = 8
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    we,
   input  logic [cache_pkg::set_w-1:0] addr,     // set index
   input  logic [data_w-1:0]       w_data,
   output logic [data_w-1:0]       r_data
);

   import cache_pkg::*;

   localparam int n_sets = 2 ** set_w;

   logic [data_w-1:0] mem [n_sets];   // one word per set

   assign r_data = mem[addr];          // read is combinational, same cycle as the lookup

   // every set cleared so valid bits and policy state start at zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 0; s < n_sets; s++) begin
            mem[s] <= '0;
         end
      end else if (we) begin
         mem[addr] <= w_data;          // new value visible after the edge
      end
   end

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

   // address split: low bits pick the set, the rest is the tag
   localparam int addr_w  = 12;
   localparam int set_w   = 3;                // 8 sets
   localparam int tag_w   = addr_w - set_w;   // 9 bit tag
   localparam int n_ways  = 4;
   localparam int nways_w = 2;                // binary way index

   // replacement policy codes
   localparam int rep_plru_tree = 0;
   localparam int rep_plru_mru  = 1;

   // both fifos share one depth
   localparam int fifo_depth = 4;
   localparam int fifo_ptr_w = 2;

   typedef logic [addr_w-1:0] req_word_t;      // request is a bare address

   typedef struct packed {
      logic               hit;       // tag matched a valid way
      logic [nways_w-1:0] way;       // hit way, or way the tag went into
      logic               evicted;   // a valid line was replaced
      logic [tag_w-1:0]   tag_echo;  // tag of the request, for in-order matching
   } resp_word_t;

   // one-hot way vector to binary index, zero if no bit is set
   function automatic logic [nways_w-1:0] onehot_to_bin(input logic [n_ways-1:0] onehot);
      logic [nways_w-1:0] bin;
      bin = '0;
      for (int i = 0; i < n_ways; i++) begin
         if (onehot[i]) bin = bin | nways_w'(i);
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

// ==== logic/cache_replacement_policy.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_replacement_policy #(
   parameter int rep_policy = cache_pkg::rep_plru_tree
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          write_en,       // one per accepted lookup
   input  logic [cache_pkg::set_w-1:0]   line_addr,      // set being looked up
   input  logic [cache_pkg::n_ways-1:0]  way_hit,        // way used by this access, one-hot
   output logic [cache_pkg::n_ways-1:0]  way_select,     // victim, one-hot
   output logic [cache_pkg::nways_w-1:0] way_select_bin  // victim, binary
);

   import cache_pkg::*;

   if (rep_policy == rep_plru_mru) begin : g_mru
      // one bit per way, set once the way has been used
      logic [n_ways-1:0] mru_in;
      logic [n_ways-1:0] mru_out;

      // mark the used way, start over when every way would be marked
      assign mru_in = (&(mru_out | way_hit)) ? way_hit : (mru_out | way_hit);

      // victim is the lowest way with a clear bit
      assign way_select[0] = ~mru_out[0];
      for (genvar i = 1; i < n_ways; i++) begin : g_sel
         assign way_select[i] = ~mru_out[i] & (&mru_out[i-1:0]);   // all lower ways used
      end

      assign way_select_bin = onehot_to_bin(way_select);

      cache_line_regfile #(
         .data_w (n_ways)
      ) mru_store (
         .clk    (clk),
         .rst_n  (rst_n),
         .we     (write_en),
         .addr   (line_addr),
         .w_data (mru_in),
         .r_data (mru_out)
      );
   end else begin : g_tree
      // heap-numbered node bits, node 1 is the root, children of n are 2n and 2n+1
      // leaves n_ways .. 2*n_ways-1 map to ways 0 .. n_ways-1
      logic [n_ways-1:1] tree_in;
      logic [n_ways-1:1] tree_out;
      logic [nways_w:0]  node;        // walk position, ends on a leaf

      // walk from the root: 0 goes left, 1 goes right
      always_comb begin
         node = (nways_w + 1)'(1);
         for (int lvl = 0; lvl < nways_w; lvl++) begin
            node = tree_out[node] ? ((node << 1) + 1'b1) : (node << 1);
         end
         way_select_bin = nways_w'(node - n_ways);
      end

      assign way_select = n_ways'(1) << way_select_bin;

      // update rule per node
      for (genvar lvl = 0; lvl < nways_w; lvl++) begin : g_level
         for (genvar j = 0; j < (1 << lvl); j++) begin : g_node
            localparam int nd   = (1 << lvl) + j;   // heap index of this node
            localparam int span = n_ways >> lvl;    // ways below this node
            localparam int base = j * span;         // first way below it

            logic left_used;
            logic right_used;

            assign left_used  = |way_hit[base +: span/2];
            assign right_used = |way_hit[base + span/2 +: span/2];

            // point away from the used side, hold when the access is not below us
            assign tree_in[nd] = left_used | (tree_out[nd] & ~right_used);
         end
      end

      cache_line_regfile #(
         .data_w (n_ways-1)
      ) tree_store (
         .clk    (clk),
         .rst_n  (rst_n),
         .we     (write_en),
         .addr   (line_addr),
         .w_data (tree_in),
         .r_data (tree_out)
      );
   end

endmodule

`default_nettype wire

// ==== logic/cache_tag_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tag_lookup #(
   parameter int rep_policy = cache_pkg::rep_plru_tree
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // request side, from the request fifo
   input  logic                  q_valid,
   output logic                  q_ready,
   input  cache_pkg::req_word_t  q_data,
   // response side, to the response fifo
   output logic                  r_valid,
   input  logic                  r_ready,
   output cache_pkg::resp_word_t r_data
);

   import cache_pkg::*;

   logic [set_w-1:0]        set_idx;
   logic [tag_w-1:0]        req_tag;
   logic [n_ways*tag_w-1:0] tag_rd;      // all ways of the set, way 0 in the low bits
   logic [n_ways*tag_w-1:0] tag_wr;
   logic [n_ways-1:0]       valid_rd;
   logic [n_ways-1:0]       valid_wr;
   logic [n_ways-1:0]       way_hit;     // one-hot, at most one way matches
   logic                    hit;
   logic [nways_w-1:0]      hit_bin;
   logic [n_ways-1:0]       victim;      // from the policy, one-hot
   logic [nways_w-1:0]      victim_bin;
   logic [n_ways-1:0]       used_way;    // way that becomes most recent
   logic                    accept;
   logic                    install;
   logic                    evicted;

   // lookup only runs when the result has somewhere to go
   assign q_ready = r_ready;
   assign r_valid = q_valid;
   assign accept  = q_valid & r_ready;

   assign set_idx = q_data[set_w-1:0];          // low bits select the set
   assign req_tag = q_data[addr_w-1:set_w];

   // compare against every way of the set
   for (genvar w = 0; w < n_ways; w++) begin : g_cmp
      assign way_hit[w] = valid_rd[w] & (tag_rd[w*tag_w +: tag_w] == req_tag);
   end

   assign hit     = |way_hit;
   assign hit_bin = onehot_to_bin(way_hit);

   // miss path, victim comes straight from the policy for this set
   assign install  = accept & ~hit;
   assign evicted  = ~hit & valid_rd[victim_bin];   // replacing a live line
   assign used_way = hit ? way_hit : victim;

   // new tag goes into the victim slot, other ways keep theirs
   always_comb begin
      tag_wr = tag_rd;
      for (int w = 0; w < n_ways; w++) begin
         if (victim[w]) tag_wr[w*tag_w +: tag_w] = req_tag;
      end
   end

   assign valid_wr = valid_rd | victim;

   assign r_data.hit      = hit;
   assign r_data.way      = hit ? hit_bin : victim_bin;
   assign r_data.evicted  = evicted;
   assign r_data.tag_echo = req_tag;

   cache_line_regfile #(
      .data_w (n_ways*tag_w)
   ) tag_store (
      .clk    (clk),
      .rst_n  (rst_n),
      .we     (install),
      .addr   (set_idx),
      .w_data (tag_wr),
      .r_data (tag_rd)
   );

   cache_line_regfile #(
      .data_w (n_ways)
   ) valid_store (
      .clk    (clk),
      .rst_n  (rst_n),
      .we     (install),
      .addr   (set_idx),
      .w_data (valid_wr),
      .r_data (valid_rd)
   );

   // policy updates on hits and misses alike
   cache_replacement_policy #(
      .rep_policy (rep_policy)
   ) policy (
      .clk            (clk),
      .rst_n          (rst_n),
      .write_en       (accept),
      .line_addr      (set_idx),
      .way_hit        (used_way),
      .way_select     (victim),
      .way_select_bin (victim_bin)
   );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the cache directory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert --top-module cache_dir_tb \
      -f tb.f -o sim_cache_dir; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/sim_cache_dir +verilator+error+limit+1000 > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error status"
   exit 1
fi

cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
   exit 0
else
   exit 1
fi

// ==== tb.f ====
logic/cache_pkg.sv
logic/cache_fifo.sv
logic/cache_line_regfile.sv
logic/cache_replacement_policy.sv
logic/cache_tag_lookup.sv
logic/cache_dir_top.sv
tb/tb_clock_gen.sv
tb/cache_dir_asserts.sv
tb/cache_dir_tb.sv

// ==== tb/cache_dir_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_dir_asserts (
   input logic                          clk,
   input logic                          rst_n,
   input logic                          req_valid,
   input logic                          req_ready,
   input logic [cache_pkg::addr_w-1:0]  req_addr,
   input logic                          resp_valid,
   input logic                          resp_ready,
   input logic                          resp_hit,
   input logic [cache_pkg::nways_w-1:0] resp_way,
   input logic                          resp_evicted,
   input logic [cache_pkg::tag_w-1:0]   resp_tag
);

   import cache_pkg::*;

   int fail_count = 0;   // assertion failures so far

   // request held steady while stalled
   req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid && !req_ready) |=> (req_valid && $stable(req_addr)))
      else begin
         $error("request valid dropped or address changed while stalled");
         fail_count++;
      end

   // response head must not move until it is taken
   resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid && !resp_ready) |=>
      (resp_valid && $stable({resp_hit, resp_way, resp_evicted, resp_tag})))
      else begin
         $error("response dropped or changed while stalled");
         fail_count++;
      end

   // no response and an open input side while in reset
   reset_idle: assert property (@(posedge clk) !rst_n |-> (!resp_valid && req_ready))
      else begin
         $error("response valid or request stall seen during reset");
         fail_count++;
      end

   // first cycle out of reset still has nothing to deliver
   reset_exit: assert property (@(posedge clk) !rst_n |=> !resp_valid)
      else begin
         $error("response valid right after reset");
         fail_count++;
      end

endmodule

bind cache_dir_top cache_dir_asserts handshake_checks (
   .clk          (clk),
   .rst_n        (rst_n),
   .req_valid    (req_valid),
   .req_ready    (req_ready),
   .req_addr     (req_addr),
   .resp_valid   (resp_valid),
   .resp_ready   (resp_ready),
   .resp_hit     (resp_hit),
   .resp_way     (resp_way),
   .resp_evicted (resp_evicted),
   .resp_tag     (resp_tag)
);

`default_nettype wire

// ==== tb/cache_dir_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_dir_tb;

   import cache_pkg::*;

   localparam int max_wait = 200;   // cycles per wait loop

   logic clk, rst_n, req_valid, req_ready, resp_valid, resp_ready;
   logic resp_hit, resp_evicted;
   logic [addr_w-1:0]  req_addr;
   logic [nways_w-1:0] resp_way;
   logic [tag_w-1:0]   resp_tag;

   logic [tag_w-1:0] m_tag [8][n_ways];   // model tags per set and way
   logic             m_valid [8][n_ways];
   logic [3:1]       m_tree [8];          // node 1 is root with node 2 over ways 0/1 and 3 over 2/3
   resp_word_t       exp_q[$];            // expected responses in request order
   string            name_q[$];
   string            test_name;
   logic [31:0]      lfsr;
   int               stall_mode;          // 0 ready, 1 held low, 2 random
   int               check_errors;
   logic [addr_w-1:0] rnd_addr [24];

   tb_clock_gen clock_gen (.clk (clk), .rst_n (rst_n));

   cache_dir_top cache_dir_top_inst (
      .clk (clk), .rst_n (rst_n),
      .req_valid (req_valid), .req_ready (req_ready), .req_addr (req_addr),
      .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_hit (resp_hit),
      .resp_way (resp_way), .resp_evicted (resp_evicted), .resp_tag (resp_tag)
   );

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val  = {val[30:0], lfsr[0]};   // one step per bit
      end
      return val;
   endfunction

   function automatic logic [addr_w-1:0] make_addr(input int tag, input int set);
      return {tag_w'(tag), set_w'(set)};
   endfunction

   // readable form of a response word
   function automatic string format_response(input resp_word_t w);
      return $sformatf("hit=%0d way=%0d evicted=%0d tag=%h",
                       w.hit, w.way, w.evicted, w.tag_echo);
   endfunction

   task automatic abort_run(input string msg);
      $display("%s (test %s)", msg, test_name);
      $display("SIMULATION FAILED");
      $finish;
   endtask

   // tree plru walks 0 left and 1 right and then points each node on the path away
   task automatic model_lookup(input logic [addr_w-1:0] addr);
      int         set, way;
      resp_word_t exp;
      set = int'(addr[set_w-1:0]);
      exp = '0;
      exp.tag_echo = addr[addr_w-1:set_w];
      way = -1;
      for (int w = 0; w < n_ways; w++) begin
         if (m_valid[set][w] && m_tag[set][w] == exp.tag_echo) way = w;
      end
      exp.hit = (way >= 0);
      if (!exp.hit) begin
         if (!m_tree[set][1]) way = m_tree[set][2] ? 1 : 0;
         else                 way = m_tree[set][3] ? 3 : 2;
         exp.evicted       = m_valid[set][way];
         m_tag[set][way]   = exp.tag_echo;   // install over the victim
         m_valid[set][way] = 1'b1;
      end
      exp.way = nways_w'(way);
      m_tree[set][1] = (way < 2);
      if (way < 2) m_tree[set][2] = (way == 0);
      else         m_tree[set][3] = (way == 2);
      exp_q.push_back(exp);
      name_q.push_back(test_name);
   endtask

   // called at edge+2 and leaves req_valid high for the next request
   task automatic send_request(input logic [addr_w-1:0] addr);
      int waited;
      waited    = 0;
      req_valid = 1'b1;
      req_addr  = addr;
      @(negedge clk);
      while (!req_ready) begin
         waited++;
         if (waited > max_wait) abort_run("timeout: request never accepted");
         @(negedge clk);
      end
      model_lookup(addr);   // accepted at the coming edge
      @(posedge clk);
      #2;
   endtask

   task automatic drain_responses();
      int waited;
      waited    = 0;
      req_valid = 1'b0;
      while (exp_q.size() != 0) begin
         waited++;
         if (waited > max_wait) abort_run("timeout: responses still outstanding");
         @(negedge clk);
      end
      @(posedge clk);
      #2;
   endtask

   // response compare at negedge where everything has settled
   always @(negedge clk) begin
      resp_word_t got;
      resp_word_t exp;
      string      name;
      if (rst_n && resp_valid && resp_ready) begin
         got = {resp_hit, resp_way, resp_evicted, resp_tag};
         if (exp_q.size() == 0) begin
            $display("response arrived with no request outstanding, tag %h", resp_tag);
            check_errors++;
         end else begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            assert (got == exp) else begin
               $display("ERROR %s: expected %s actual %s", name,
                        format_response(exp), format_response(got));
               check_errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      logic [31:0] r;
      #2;
      if (stall_mode == 2) begin
         r          = take_bits(1);
         resp_ready = r[0];
      end else begin
         resp_ready = (stall_mode == 0);
      end
   end

   initial begin
      int waited;
      int total;
      logic [31:0] r;
      req_valid    = 1'b0;
      req_addr     = '0;
      resp_ready   = 1'b1;
      stall_mode   = 0;
      check_errors = 0;
      lfsr         = 32'h6779_922b;
      test_name    = "reset";
      waited       = 0;
      for (int s = 0; s < 8; s++) begin
         m_tree[s] = '0;
         for (int w = 0; w < n_ways; w++) begin
            m_tag[s][w]   = '0;
            m_valid[s][w] = 1'b0;
         end
      end
      while (!rst_n) begin
         waited++;
         if (waited > max_wait) abort_run("timeout: reset never released");
         @(posedge clk);
      end
      @(posedge clk);
      #2;
      test_name = "first_access";
      send_request(make_addr('h011, 1));
      send_request(make_addr('h0a3, 5));
      test_name = "repeat_access";
      send_request(make_addr('h011, 1));
      send_request(make_addr('h0a3, 5));
      test_name = "fill_set";   // ways 0 2 1 3
      for (int t = 1; t <= 4; t++) send_request(make_addr(t, 2));
      test_name = "fifth_tag";
      send_request(make_addr(5, 2));   // way 0 evicted
      send_request(make_addr(1, 2));   // evicted tag misses again
      test_name = "independent_sets";
      for (int i = 0; i < 6; i++) begin
         send_request(make_addr(9'h020 + i, 3));
         send_request(make_addr(9'h040 + i, 4));
      end
      drain_responses();
      test_name  = "back_pressure";
      stall_mode = 1;
      @(posedge clk);
      #2;
      for (int i = 0; i < 8; i++) send_request(make_addr(9'h060 + i, i));
      req_valid = 1'b0;
      @(negedge clk);
      assert (req_ready == 1'b0) else begin
         $display("ERROR %s: expected req_ready=0 actual req_ready=%0d", test_name, req_ready);
         check_errors++;
      end
      for (int i = 0; i < 24; i++) begin
         r           = take_bits(6);
         rnd_addr[i] = {6'b0, r[5:3], r[2:0]};   // small tag pool gives hits and evictions
      end
      stall_mode = 2;
      @(posedge clk);
      #2;
      for (int i = 0; i < 24; i++) send_request(rnd_addr[i]);
      drain_responses();
      stall_mode = 0;
      total = check_errors + cache_dir_top_inst.handshake_checks.fail_count;
      $display("errors: %0d response checks, %0d assertions", check_errors,
               cache_dir_top_inst.handshake_checks.fail_count);
      if (total == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   localparam time half_period = 10ns;   // 20 ns clock
   localparam int  reset_cycles = 8;

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // reset released just after an edge so it never races the flops
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #2 rst_n = 1'b1;
   end

endmodule

`default_nettype wire
